// File: all.f
+incdir+hw
+incdir+sim
hw/pma_pkg.sv
hw/pma_region_lookup.sv
hw/pma_mpu.sv
hw/bus_arbiter.sv
hw/data_ram.sv
hw/pma_event_counters.sv
hw/pma_subsys_top.sv
sim/tb_pma_subsys.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pma_subsys
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

# The simulator status is lost in the pipe, the log decides pass or fail
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx 'Test OK' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_pma_table.svh
// ----------------------------
// Stimulus table for the PMA testbench
// Included inside the testbench module body
// ----------------------------

`ifndef TB_PMA_TABLE_SVH
`define TB_PMA_TABLE_SVH

// Columns: both, side (0 instr, 1 data), addr, we, size, rnd, wdata, exp_fault {d, i}
typedef struct packed {
  logic         both;
  logic         side;
  logic [31:0]  addr;
  logic         we;
  access_size_e size;
  logic         rnd;
  logic [31:0]  wdata;
  logic [1:0]   exp_fault;
} tb_row_t;

localparam int NUM_ROWS = 38;

localparam tb_row_t ROWS [NUM_ROWS] = '{
  // Word round trip on region 0, then a fetch of the same word
  '{1'b0, 1'b1, 32'h0000_0000, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0000, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b0, 32'h0000_0000, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  // Aligned byte and half writes
  '{1'b0, 1'b1, 32'h0000_0004, 1'b1, SIZE_WORD, 1'b0, 32'h1122_3344, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0005, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_00aa, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0006, 1'b1, SIZE_HALF, 1'b0, 32'h0000_beef, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0004, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  // Misaligned on main, the last half is clipped to byte 3
  '{1'b0, 1'b1, 32'h0000_0008, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0009, 1'b1, SIZE_HALF, 1'b0, 32'h0000_5566, 2'b00},
  '{1'b0, 1'b1, 32'h0000_000b, 1'b1, SIZE_HALF, 1'b0, 32'h0000_3377, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0008, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_000c, 1'b1, SIZE_WORD, 1'b0, 32'hcafe_f00d, 2'b00},
  '{1'b0, 1'b1, 32'h0000_000d, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_000e, 1'b0, SIZE_BYTE, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_000c, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  // Overlap of regions 0 and 1
  '{1'b0, 1'b1, 32'h0000_0100, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_01fc, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_01ff, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_005a, 2'b00},
  '{1'b0, 1'b1, 32'h0000_01fc, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b0, 32'h0000_0100, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  // I/O region 2, misaligned data faults and fetch faults
  '{1'b0, 1'b1, 32'h0000_0200, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0201, 1'b1, SIZE_HALF, 1'b0, 32'h0000_dead, 2'b10},
  '{1'b0, 1'b1, 32'h0000_0202, 1'b1, SIZE_WORD, 1'b0, 32'hffff_ffff, 2'b10},
  '{1'b0, 1'b1, 32'h0000_0203, 1'b0, SIZE_HALF, 1'b0, 32'h0000_0000, 2'b10},
  '{1'b0, 1'b1, 32'h0000_0200, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b0, 32'h0000_0200, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b01},
  // Unmapped space and fetch shape rules, 0x500 aliases 0x100
  '{1'b0, 1'b0, 32'h0000_0500, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b01},
  '{1'b0, 1'b1, 32'h0000_0500, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b0, 32'h0000_0000, 1'b0, SIZE_HALF, 1'b0, 32'h0000_0000, 2'b01},
  '{1'b0, 1'b0, 32'h0000_0002, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b01},
  // Region 3
  '{1'b0, 1'b1, 32'h0000_0300, 1'b1, SIZE_WORD, 1'b1, 32'h0000_0000, 2'b00},
  '{1'b0, 1'b1, 32'h0000_0303, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0099, 2'b00},
  '{1'b0, 1'b0, 32'h0000_0300, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  // Both sides in the same cycle
  '{1'b1, 1'b0, 32'h0000_0000, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b1, 1'b0, 32'h0000_0200, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b01},
  '{1'b1, 1'b0, 32'h0000_0100, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b1, 1'b0, 32'h0000_000c, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 2'b00},
  '{1'b1, 1'b0, 32'h0000_0302, 1'b0, SIZE_HALF, 1'b0, 32'h0000_0000, 2'b01}
};

`endif

// File: sim/tb_pma_subsys.sv
// ----------------------------
// Testbench for the PMA subsystem
// Applies the stimulus table and checks each response
// against a model of the PMA rules and a shadow RAM
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module tb_pma_subsys;

  import pma_pkg::*;

  `include "tb_pma_table.svh"

  localparam int TIMEOUT_CYCLES    = 20;
  localparam int NUM_MODEL_REGIONS = 4;

  // Region map of the model, lowest index wins
  localparam logic [31:0] MODEL_BASE [NUM_MODEL_REGIONS] = '{
    32'h0000_0000, 32'h0000_0100, 32'h0000_0200, 32'h0000_0300
  };
  localparam logic [31:0] MODEL_SIZE [NUM_MODEL_REGIONS] = '{
    32'd512, 32'd256, 32'd256, 32'd256
  };
  localparam logic MODEL_MAIN [NUM_MODEL_REGIONS] = '{1'b1, 1'b1, 1'b0, 1'b1};

  logic              clk_ungated = 1'b0;
  logic              rst_n;
  core_req_t         icore_req;
  core_req_t         dcore_req;
  core_rsp_t         icore_rsp;
  core_rsp_t         dcore_rsp;
  logic              ibusy;
  logic              dbusy;
  logic [`CNT_W-1:0] cnt_access;
  logic [`CNT_W-1:0] cnt_fault;
  logic [`CNT_W-1:0] cnt_multi;
  logic [`CNT_W-1:0] cnt_io;

  logic [31:0] shadow [`RAM_WORDS];
  int          tot_access;
  int          tot_fault;
  int          tot_multi;
  int          tot_io;

  pma_subsys_top UUT (
    .clk_ungated  (clk_ungated),
    .rst_n        (rst_n),
    .icore_req_i  (icore_req),
    .dcore_req_i  (dcore_req),
    .icore_rsp_o  (icore_rsp),
    .dcore_rsp_o  (dcore_rsp),
    .ibusy_o      (ibusy),
    .dbusy_o      (dbusy),
    .cnt_access_o (cnt_access),
    .cnt_fault_o  (cnt_fault),
    .cnt_multi_o  (cnt_multi),
    .cnt_io_o     (cnt_io)
  );

  always #10 clk_ungated = ~clk_ungated;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=0x%08h expected=0x%08h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    $display("Test FAILED");
    $fatal(1, "no response from the DUT");
  endtask

  // Winner's main bit and whether more than one region hits
  function automatic void region_attrs(input logic [31:0] addr, output logic main,
                                       output logic multi);
    int hits;
    hits = 0;
    main = 1'b0;
    for (int i = 0; i < NUM_MODEL_REGIONS; i++) begin
      if (addr >= MODEL_BASE[i] && addr < MODEL_BASE[i] + MODEL_SIZE[i]) begin
        if (hits == 0) begin
          main = MODEL_MAIN[i];
        end
        hits++;
      end
    end
    multi = (hits > 1);
  endfunction

  function automatic logic access_allowed(input logic instr, input logic [31:0] addr,
                                          input access_size_e size, input logic main);
    logic misaligned;
    misaligned = ((size == SIZE_HALF) && addr[0]) ||
                 ((size == SIZE_WORD) && (addr[1:0] != 2'b00));
    if (instr) begin
      return (size == SIZE_WORD) && !misaligned && main;
    end else begin
      return main || !misaligned;
    end
  endfunction

  function automatic logic [3:0] lane_mask(input logic [1:0] off, input access_size_e size);
    logic [6:0] span;
    case (size)
      SIZE_BYTE: span = 7'b000_0001;
      SIZE_HALF: span = 7'b000_0011;
      default:   span = 7'b000_1111;
    endcase
    span = span << off;
    // Lanes past byte 3 fall outside the word
    return span[3:0];
  endfunction

  function automatic void store_shadow(input logic [31:0] addr, input access_size_e size,
                                       input logic [31:0] wdata);
    logic [3:0]  be;
    logic [31:0] lanes;
    be    = lane_mask(addr[1:0], size);
    lanes = wdata << {addr[1:0], 3'b000};
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        shadow[addr[9:2]][8*b +: 8] = lanes[8*b +: 8];
      end
    end
  endfunction

  // Issue one table row and follow each issued side to its response
  task automatic run_row(input tb_row_t row);
    core_req_t   req;
    core_rsp_t   rsp;
    logic [1:0]  issue;
    logic [1:0]  done;
    logic [1:0]  busy_pending;
    logic [1:0]  fault_m;
    logic [31:0] rdata_m [2];
    logic        main_m;
    logic        multi_m;
    logic        busy;
    string       rsp_name;
    string       busy_name;
    int          cycles;

    issue     = row.both ? 2'b11 : (row.side ? 2'b10 : 2'b01);
    req.valid = 1'b1;
    req.addr  = row.addr;
    req.we    = row.we;
    req.size  = row.size;
    req.wdata = row.rnd ? $urandom : row.wdata;

    region_attrs(row.addr, main_m, multi_m);
    for (int s = 0; s < 2; s++) begin
      fault_m[s] = !access_allowed(s == 0, row.addr, row.size, main_m);
      rdata_m[s] = (fault_m[s] || row.we) ? 32'h0 : shadow[row.addr[9:2]];
      if (issue[s]) begin
        check_value("model fault against table", 32'(fault_m[s]), 32'(row.exp_fault[s]));
        tot_access++;
        tot_fault += int'(fault_m[s]);
        tot_multi += int'(multi_m);
        tot_io    += int'(!main_m);
      end
    end
    for (int s = 0; s < 2; s++) begin
      if (issue[s] && row.we && !fault_m[s]) begin
        store_shadow(row.addr, row.size, req.wdata);
      end
    end

    @(posedge clk_ungated);
    if (issue[0]) begin
      icore_req <= req;
    end
    if (issue[1]) begin
      dcore_req <= req;
    end
    @(posedge clk_ungated);
    icore_req.valid <= 1'b0;
    dcore_req.valid <= 1'b0;

    // Cycle 1 is the decision cycle after the capture edge
    done         = ~issue;
    busy_pending = 2'b00;
    cycles       = 0;
    while (done != 2'b11 || busy_pending != 2'b00) begin
      @(negedge clk_ungated);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout("a core response");
      end
      for (int s = 0; s < 2; s++) begin
        rsp       = (s == 1) ? dcore_rsp : icore_rsp;
        busy      = (s == 1) ? dbusy : ibusy;
        rsp_name  = (s == 1) ? "dcore_rsp_o" : "icore_rsp_o";
        busy_name = (s == 1) ? "dbusy_o" : "ibusy_o";
        if (busy_pending[s]) begin
          check_value(busy_name, 32'(busy), 32'h0);
          busy_pending[s] = 1'b0;
        end else if (!done[s]) begin
          check_value(busy_name, 32'(busy), 32'h1);
          if (rsp.valid) begin
            check_value({rsp_name, ".fault"}, 32'(rsp.fault), 32'(fault_m[s]));
            check_value({rsp_name, ".rdata"}, rsp.rdata, rdata_m[s]);
            // Contention only delays allowed accesses
            if (fault_m[s] || !row.both) begin
              check_value({rsp_name, " latency"}, 32'(cycles), fault_m[s] ? 32'd1 : 32'd2);
            end
            done[s]         = 1'b1;
            busy_pending[s] = 1'b1;
          end
        end
      end
    end
  endtask

  initial begin
    void'($urandom(64095));
    rst_n      = 1'b0;
    icore_req  = '0;
    dcore_req  = '0;
    tot_access = 0;
    tot_fault  = 0;
    tot_multi  = 0;
    tot_io     = 0;

    repeat (8) @(posedge clk_ungated);
    rst_n <= 1'b1;
    @(negedge clk_ungated);
    check_value("ibusy_o", 32'(ibusy), 32'h0);
    check_value("dbusy_o", 32'(dbusy), 32'h0);
    check_value("icore_rsp_o.valid", 32'(icore_rsp.valid), 32'h0);
    check_value("dcore_rsp_o.valid", 32'(dcore_rsp.valid), 32'h0);
    check_value("cnt_access_o", 32'(cnt_access), 32'h0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(ROWS[r]);
    end

    @(negedge clk_ungated);
    check_value("cnt_access_o", 32'(cnt_access), 32'(tot_access));
    check_value("cnt_fault_o", 32'(cnt_fault), 32'(tot_fault));
    check_value("cnt_multi_o", 32'(cnt_multi), 32'(tot_multi));
    check_value("cnt_io_o", 32'(cnt_io), 32'(tot_io));

    $display("Test OK");
    $finish;
  end

endmodule

// File: hw/pma_subsys_top.sv
// ----------------------------
// PMA subsystem top level
// Two MPUs share one RAM, counters watch both
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module pma_subsys_top (
  input  logic               clk_ungated,
  input  logic               rst_n,
  input  pma_pkg::core_req_t icore_req_i,
  input  pma_pkg::core_req_t dcore_req_i,
  output pma_pkg::core_rsp_t icore_rsp_o,
  output pma_pkg::core_rsp_t dcore_rsp_o,
  output logic               ibusy_o,
  output logic               dbusy_o,
  output logic [`CNT_W-1:0]  cnt_access_o,
  output logic [`CNT_W-1:0]  cnt_fault_o,
  output logic [`CNT_W-1:0]  cnt_multi_o,
  output logic [`CNT_W-1:0]  cnt_io_o
);

  import pma_pkg::*;

  bus_req_t           ibus_req;
  bus_req_t           dbus_req;
  mpu_event_t         ievent;
  mpu_event_t         devent;
  logic [1:0]         gnt;
  logic [1:0]         rvalid;
  logic [31:0]        bus_rdata;
  logic               ram_en;
  logic               ram_we;
  logic [`RAM_AW-1:0] ram_addr;
  logic [3:0]         ram_be;
  logic [31:0]        ram_wdata;
  logic [31:0]        ram_rdata;

  pma_mpu #(.IS_INSTR_SIDE(1'b1)) u_impu (
    .clk_ungated (clk_ungated),
    .rst_n       (rst_n),
    .core_req_i  (icore_req_i),
    .core_rsp_o  (icore_rsp_o),
    .busy_o      (ibusy_o),
    .bus_req_o   (ibus_req),
    .gnt_i       (gnt[0]),
    .rvalid_i    (rvalid[0]),
    .rdata_i     (bus_rdata),
    .event_o     (ievent)
  );

  pma_mpu #(.IS_INSTR_SIDE(1'b0)) u_dmpu (
    .clk_ungated (clk_ungated),
    .rst_n       (rst_n),
    .core_req_i  (dcore_req_i),
    .core_rsp_o  (dcore_rsp_o),
    .busy_o      (dbusy_o),
    .bus_req_o   (dbus_req),
    .gnt_i       (gnt[1]),
    .rvalid_i    (rvalid[1]),
    .rdata_i     (bus_rdata),
    .event_o     (devent)
  );

  bus_arbiter u_arbiter (
    .clk_ungated (clk_ungated),
    .rst_n       (rst_n),
    .ireq_i      (ibus_req),
    .dreq_i      (dbus_req),
    .gnt_o       (gnt),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_be_o    (ram_be),
    .ram_wdata_o (ram_wdata),
    .ram_rdata_i (ram_rdata),
    .rvalid_o    (rvalid),
    .rdata_o     (bus_rdata)
  );

  data_ram u_ram (
    .clk_ungated (clk_ungated),
    .en_i        (ram_en),
    .we_i        (ram_we),
    .addr_i      (ram_addr),
    .be_i        (ram_be),
    .wdata_i     (ram_wdata),
    .rdata_o     (ram_rdata)
  );

  pma_event_counters u_counters (
    .clk_ungated  (clk_ungated),
    .rst_n        (rst_n),
    .ievent_i     (ievent),
    .devent_i     (devent),
    .cnt_access_o (cnt_access_o),
    .cnt_fault_o  (cnt_fault_o),
    .cnt_multi_o  (cnt_multi_o),
    .cnt_io_o     (cnt_io_o)
  );

endmodule

// File: hw/pma_event_counters.sv
// ----------------------------
// Event counters for both PMA units
// Counts on the edge after an activate pulse
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module pma_event_counters (
  input  logic                clk_ungated,
  input  logic                rst_n,
  input  pma_pkg::mpu_event_t ievent_i,
  input  pma_pkg::mpu_event_t devent_i,
  output logic [`CNT_W-1:0]   cnt_access_o,
  output logic [`CNT_W-1:0]   cnt_fault_o,
  output logic [`CNT_W-1:0]   cnt_multi_o,
  output logic [`CNT_W-1:0]   cnt_io_o
);

  localparam int NUM_CNT = 4;

  // Index 0 access, 1 fault, 2 multimatch, 3 I/O
  logic [NUM_CNT-1:0] ihit;
  logic [NUM_CNT-1:0] dhit;
  logic [`CNT_W-1:0]  cnt_q [NUM_CNT];

  function automatic logic [`CNT_W-1:0] sat_add(input logic [`CNT_W-1:0] base,
                                                input logic [1:0]        inc);
    logic [`CNT_W:0] sum;
    sum = {1'b0, base} + {{(`CNT_W-1){1'b0}}, inc};
    return sum[`CNT_W] ? '1 : sum[`CNT_W-1:0];
  endfunction

  assign ihit = {ievent_i.activate && !ievent_i.main,
                 ievent_i.activate && ievent_i.multi,
                 ievent_i.activate && ievent_i.fault,
                 ievent_i.activate};
  assign dhit = {devent_i.activate && !devent_i.main,
                 devent_i.activate && devent_i.multi,
                 devent_i.activate && devent_i.fault,
                 devent_i.activate};

  // Both units may fire in the same cycle
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_CNT; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NUM_CNT; k++) begin
        cnt_q[k] <= sat_add(cnt_q[k], {1'b0, ihit[k]} + {1'b0, dhit[k]});
      end
    end
  end

  assign cnt_access_o = cnt_q[0];
  assign cnt_fault_o  = cnt_q[1];
  assign cnt_multi_o  = cnt_q[2];
  assign cnt_io_o     = cnt_q[3];

  a_counts_bounded: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    (cnt_fault_o <= cnt_access_o) && (cnt_io_o <= cnt_access_o)
  ) else $error("fault or I/O count above access count");

endmodule

// File: hw/data_ram.sv
// ----------------------------
// Word RAM with byte write enables
// Read data appears one cycle after en
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module data_ram (
  input  logic               clk_ungated,
  input  logic               en_i,
  input  logic               we_i,
  input  logic [`RAM_AW-1:0] addr_i,
  input  logic [3:0]         be_i,
  input  logic [31:0]        wdata_i,
  output logic [31:0]        rdata_o
);

  logic [31:0] mem [`RAM_WORDS];

  // Output register holds its word until the next read
  always_ff @(posedge clk_ungated) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: hw/bus_arbiter.sv
// ----------------------------
// Round-robin RAM arbiter for two MPUs
// Bit 0 is the instruction side, bit 1 the data side
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module bus_arbiter (
  input  logic              clk_ungated,
  input  logic              rst_n,
  input  pma_pkg::bus_req_t ireq_i,
  input  pma_pkg::bus_req_t dreq_i,
  output logic [1:0]        gnt_o,
  output logic              ram_en_o,
  output logic              ram_we_o,
  output logic [`RAM_AW-1:0] ram_addr_o,
  output logic [3:0]        ram_be_o,
  output logic [31:0]       ram_wdata_o,
  input  logic [31:0]       ram_rdata_i,
  output logic [1:0]        rvalid_o,
  output logic [31:0]       rdata_o
);

  import pma_pkg::*;

  bus_req_t sel_req;
  logic     last_instr_q;
  logic     in_flight_q;

  // No grant while a read waits for its data
  always_comb begin
    gnt_o = 2'b00;
    if (!in_flight_q) begin
      if (ireq_i.req && dreq_i.req) begin
        gnt_o = last_instr_q ? 2'b10 : 2'b01;
      end else if (ireq_i.req) begin
        gnt_o = 2'b01;
      end else if (dreq_i.req) begin
        gnt_o = 2'b10;
      end
    end
  end

  assign sel_req     = gnt_o[1] ? dreq_i : ireq_i;
  assign ram_en_o    = |gnt_o;
  assign ram_we_o    = sel_req.we;
  assign ram_addr_o  = sel_req.addr[`RAM_AW-1:0];
  assign ram_be_o    = sel_req.be;
  assign ram_wdata_o = sel_req.wdata;
  assign rdata_o     = ram_rdata_i;

  // rvalid also acknowledges writes one cycle after the grant
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_o     <= 2'b00;
      in_flight_q  <= 1'b0;
      last_instr_q <= 1'b0;
    end else begin
      rvalid_o    <= gnt_o;
      in_flight_q <= ram_en_o && !ram_we_o;
      if (gnt_o[0]) begin
        last_instr_q <= 1'b1;
      end else if (gnt_o[1]) begin
        last_instr_q <= 1'b0;
      end
    end
  end

  a_gnt_onehot: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    $onehot0(gnt_o)
  ) else $error("more than one grant");

endmodule

// File: hw/pma_mpu.sv
// ----------------------------
// PMA unit for one side of the core
// Checks a captured request and runs it on the RAM bus
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module pma_mpu #(
  parameter bit IS_INSTR_SIDE = 1'b0
) (
  input  logic                clk_ungated,
  input  logic                rst_n,
  input  pma_pkg::core_req_t  core_req_i,
  output pma_pkg::core_rsp_t  core_rsp_o,
  output logic                busy_o,
  output pma_pkg::bus_req_t   bus_req_o,
  input  logic                gnt_i,
  input  logic                rvalid_i,
  input  logic [31:0]         rdata_i,
  output pma_pkg::mpu_event_t event_o
);

  import pma_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DECIDE,
    ST_WAIT_GNT,
    ST_WAIT_DATA
  } mpu_state_e;

  mpu_state_e  state_q;
  mpu_state_e  state_d;
  core_req_t   req_q;
  pma_status_t status;
  logic [1:0]  offset;
  logic        decide;
  logic        misaligned;
  logic        allow;
  logic        rsp_data;

  pma_region_lookup u_lookup (
    .addr_i   (req_q.addr),
    .status_o (status)
  );

  always_ff @(posedge clk_ungated) begin
    if (state_q == ST_IDLE && core_req_i.valid) begin
      req_q <= core_req_i;
    end
  end

  assign offset = req_q.addr[1:0];
  assign decide = (state_q == ST_DECIDE);

  always_comb begin
    case (req_q.size)
      SIZE_HALF: misaligned = offset[0];
      SIZE_WORD: misaligned = (offset != 2'b00);
      default:   misaligned = 1'b0;
    endcase
  end

  // Fetch needs an aligned word in main memory
  assign allow = IS_INSTR_SIDE ? (req_q.size == SIZE_WORD && !misaligned && status.main)
                               : !(misaligned && !status.main);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (core_req_i.valid) state_d = ST_DECIDE;
      end
      ST_DECIDE: begin
        if (!allow) state_d = ST_IDLE;
        else if (gnt_i) state_d = ST_WAIT_DATA;
        else state_d = ST_WAIT_GNT;
      end
      ST_WAIT_GNT: begin
        if (gnt_i) state_d = ST_WAIT_DATA;
      end
      default: begin
        if (rvalid_i) state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign busy_o = (state_q != ST_IDLE);

  // Byte enables shifted by the offset drop whatever spills past the word
  always_comb begin
    bus_req_o.req   = (decide && allow) || (state_q == ST_WAIT_GNT);
    bus_req_o.addr  = req_q.addr[`PMA_ADDR_W-1:2];
    bus_req_o.we    = req_q.we;
    bus_req_o.wdata = req_q.wdata << {offset, 3'b000};
    case (req_q.size)
      SIZE_BYTE: bus_req_o.be = 4'b0001 << offset;
      SIZE_HALF: bus_req_o.be = 4'b0011 << offset;
      default:   bus_req_o.be = 4'b1111 << offset;
    endcase
  end

  // Read data is the whole word, the core picks its lanes
  assign rsp_data         = (state_q == ST_WAIT_DATA) && rvalid_i;
  assign core_rsp_o.valid = (decide && !allow) || rsp_data;
  assign core_rsp_o.fault = decide && !allow;
  assign core_rsp_o.rdata = (rsp_data && !req_q.we) ? rdata_i : '0;

  assign event_o.activate = decide;
  assign event_o.fault    = !allow;
  assign event_o.multi    = ($countones(status.match_list) > 1);
  assign event_o.main     = status.main;

  a_no_req_while_busy: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    core_req_i.valid |-> !busy_o
  ) else $error("request while busy");

  // Lower priority hits behind the winner must show up as a multimatch
  a_multi_matches_list: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    event_o.activate |->
      (event_o.multi == ((status.match_list >> (int'(status.match_idx) + 1)) != '0))
  ) else $error("multimatch event disagrees with match list");

endmodule

// File: hw/pma_region_lookup.sv
// ----------------------------
// Combinational region match
// Lowest matching index wins, no match is I/O
// ----------------------------

`timescale 1ns/100ps
`include "pma_defs.svh"

module pma_region_lookup (
  input  logic [`PMA_ADDR_W-1:0] addr_i,
  output pma_pkg::pma_status_t   status_o
);

  import pma_pkg::*;

  logic [`PMA_NUM_REGIONS-1:0] hit;

  // Range check per entry, base inclusive and end exclusive
  always_comb begin
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      hit[i] = (addr_i >= PMA_REGIONS[i].base) &&
               ((addr_i - PMA_REGIONS[i].base) < PMA_REGIONS[i].size);
    end
  end

  always_comb begin
    // Defaults describe an unmapped I/O access
    status_o            = '0;
    status_o.match_list = hit;
    status_o.have_match = |hit;

    // Walk downwards so the lowest hit is written last
    for (int i = `PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        status_o.match_idx  = 4'(i);
        status_o.main       = PMA_REGIONS[i].main;
        status_o.bufferable = PMA_REGIONS[i].bufferable;
        status_o.cacheable  = PMA_REGIONS[i].cacheable;
        status_o.integrity  = PMA_REGIONS[i].integrity;
      end
    end
  end

endmodule

// File: hw/pma_pkg.sv
// ----------------------------
// Shared PMA types and the region table
// Import in module bodies, scoped names in ports
// ----------------------------

`include "pma_defs.svh"

package pma_pkg;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // One table entry, size is in bytes
  typedef struct packed {
    logic [`PMA_ADDR_W-1:0] base;
    logic [`PMA_ADDR_W-1:0] size;
    logic                   main;
    logic                   bufferable;
    logic                   cacheable;
    logic                   integrity;
  } pma_region_t;

  typedef struct packed {
    logic                        have_match;
    logic [3:0]                  match_idx;
    logic [`PMA_NUM_REGIONS-1:0] match_list;
    logic                        main;
    logic                        bufferable;
    logic                        cacheable;
    logic                        integrity;
  } pma_status_t;

  typedef struct packed {
    logic                   valid;
    logic [`PMA_ADDR_W-1:0] addr;
    logic                   we;
    access_size_e           size;
    logic [31:0]            wdata;
  } core_req_t;

  typedef struct packed {
    logic        valid;
    logic        fault;
    logic [31:0] rdata;
  } core_rsp_t;

  // Word addressed, wdata already placed in its byte lanes
  typedef struct packed {
    logic                   req;
    logic [`PMA_ADDR_W-3:0] addr;
    logic                   we;
    logic [3:0]             be;
    logic [31:0]            wdata;
  } bus_req_t;

  typedef struct packed {
    logic activate;
    logic fault;
    logic multi;
    logic main;
  } mpu_event_t;

  // Region 1 sits inside region 0 on purpose to exercise priority
  localparam pma_region_t PMA_REGIONS [`PMA_NUM_REGIONS] = '{
    '{base: 'h0000, size: 'd512, main: 1'b1,
      bufferable: 1'b0, cacheable: 1'b1, integrity: 1'b0},
    '{base: 'h0100, size: 'd256, main: 1'b1,
      bufferable: 1'b1, cacheable: 1'b0, integrity: 1'b0},
    '{base: 'h0200, size: 'd256, main: 1'b0,
      bufferable: 1'b1, cacheable: 1'b0, integrity: 1'b0},
    '{base: 'h0300, size: 'd256, main: 1'b1,
      bufferable: 1'b0, cacheable: 1'b0, integrity: 1'b1}
  };

endpackage

// File: hw/pma_defs.svh
// ----------------------------
// Sizing macros for the PMA subsystem
// Include wherever a width or depth is needed
// ----------------------------

`ifndef PMA_DEFS_SVH
`define PMA_DEFS_SVH

// Entries in the fixed region table (1 to 16)
`define PMA_NUM_REGIONS 4

// Byte address width on the core side
`define PMA_ADDR_W 32

// RAM depth in 32-bit words
`define RAM_WORDS 256

// RAM word index width, address bits 9:2 for 256 words
`define RAM_AW $clog2(`RAM_WORDS)

// Width of each event counter
`define CNT_W 16

`endif
